// File: hdl/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

//==========================================================
// datapath widths
//==========================================================
`define OOO_WORD_W		16	// register and bus data
`define OOO_INSTR_W		16	// one instruction word

//==========================================================
// storage sizes
//==========================================================
`define OOO_AREG_NUM	8	// architectural registers
`define OOO_AREG_W		3

`define OOO_ROB_DEPTH	8	// reorder buffer slots
`define OOO_ROB_W		3	// tag width, a tag is a rob index

`define OOO_RS_NUM		4	// reservation station entries

`endif

// File: hdl/ooo_pkg.sv
package ooo_pkg;

	`include "ooo_macros.svh"

	// opcode field, instr[15:13]
	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_ADDI,	// a + zero-extended imm
		OP_SHL,
		OP_SHR
	} alu_op_e;

	// entry life cycle
	typedef enum logic [1:0] {
		RS_FREE,
		RS_WAIT,	// at least one operand missing
		RS_READY	// both captured, asks for issue
	} rs_state_e;

	typedef logic [`OOO_AREG_W-1:0]	areg_t;
	typedef logic [`OOO_ROB_W-1:0]	rob_tag_t;
	typedef logic [`OOO_WORD_W-1:0]	word_t;

	// common data bus, one result per cycle
	typedef struct packed {
		logic		valid;
		rob_tag_t	tag;
		word_t		value;
	} cdb_t;

	// what an entry hands to the alu
	typedef struct packed {
		alu_op_e	op;
		rob_tag_t	dest;
		word_t		val_a;
		word_t		val_b;
	} rs_issue_t;

	// source operand, value when rdy else tag to wait for
	typedef struct packed {
		logic		rdy;
		rob_tag_t	tag;
		word_t		value;
	} operand_t;

endpackage: ooo_pkg

// File: hdl/ooo_ifs.sv
`timescale 1ns/10ps
`include "ooo_macros.svh"

//==========================================================
// rename -> reservation stations
//==========================================================
interface dispatch_if;
	import ooo_pkg::*;

	logic [`OOO_RS_NUM-1:0]	alloc_onehot;	// zero when nothing dispatched
	alu_op_e				op;
	rob_tag_t				dest;			// rob tail of the new instr
	operand_t				opa;
	operand_t				opb;			// holds imm for addi

	modport rename (
		output alloc_onehot, op, dest, opa, opb
	);

	modport entry (
		input alloc_onehot, op, dest, opa, opb
	);

endinterface: dispatch_if

//==========================================================
// rename <-> reorder buffer
//==========================================================
interface rob_if;
	import ooo_pkg::*;

	logic		alloc_en;
	areg_t		alloc_areg;
	rob_tag_t	rda_tag, rdb_tag;	// operand read ports
	rob_tag_t	tail;
	logic		full;
	logic		rda_done, rdb_done;
	word_t		rda_val, rdb_val;
	logic		retire_vld;			// one pulse per retired instr
	rob_tag_t	retire_tag;
	areg_t		retire_areg;
	word_t		retire_val;

	modport rename (
		output alloc_en, alloc_areg, rda_tag, rdb_tag,
		input  tail, full, rda_done, rda_val, rdb_done, rdb_val,
		input  retire_vld, retire_tag, retire_areg, retire_val
	);

	modport rob (
		input  alloc_en, alloc_areg, rda_tag, rdb_tag,
		output tail, full, rda_done, rda_val, rdb_done, rdb_val,
		output retire_vld, retire_tag, retire_areg, retire_val
	);

endinterface: rob_if

// File: hdl/rename_unit.sv
`timescale 1ns/10ps
`include "ooo_macros.svh"

module rename_unit (
	input  logic					clk,
	input  logic					rst_n_i,
	input  logic					wb_cyc_i,
	input  logic					wb_stb_i,
	input  ooo_pkg::word_t			wb_dat_i,
	output logic					wb_ack_o,
	input  logic [`OOO_RS_NUM-1:0]	rs_busy_i,
	input  ooo_pkg::cdb_t			cdb_i,
	dispatch_if.rename				disp,
	rob_if.rename					robp
);
	import ooo_pkg::*;

	alu_op_e				dec_op;
	areg_t					dec_dest, dec_srca, dec_srcb;
	logic [3:0]				dec_imm;
	logic [`OOO_RS_NUM-1:0]	free_onehot;
	logic					any_free;
	logic					accept;
	logic					ack_q;
	operand_t				opa, opb;

	word_t					arf [`OOO_AREG_NUM];		// committed state
	logic [`OOO_AREG_NUM-1:0]	map_vld;				// reg has an in-flight producer
	rob_tag_t				map_tag [`OOO_AREG_NUM];

	// value source priority: arf, rob, bus, else wait on tag
	function automatic operand_t lookup(input logic mapped, input rob_tag_t tag,
			input word_t arf_val, input logic rob_done, input word_t rob_val,
			input cdb_t cdb);
		operand_t res;
		res.tag = tag;
		if (!mapped) begin
			res.rdy   = 1'b1;
			res.value = arf_val;
		end else if (rob_done) begin
			res.rdy   = 1'b1;
			res.value = rob_val;
		end else if (cdb.valid && cdb.tag == tag) begin
			res.rdy   = 1'b1;	// result on the bus right now
			res.value = cdb.value;
		end else begin
			res.rdy   = 1'b0;
			res.value = '0;
		end
		return res;
	endfunction

	//==========================================================
	// decode
	//==========================================================
	assign dec_op   = alu_op_e'(wb_dat_i[15:13]);
	assign dec_dest = wb_dat_i[12:10];
	assign dec_srca = wb_dat_i[9:7];
	assign dec_srcb = wb_dat_i[6:4];
	assign dec_imm  = wb_dat_i[3:0];

	// lowest free entry wins
	always_comb begin
		free_onehot = '0;
		for (int i = `OOO_RS_NUM-1; i >= 0; i--) begin
			if (!rs_busy_i[i]) begin
				free_onehot    = '0;
				free_onehot[i] = 1'b1;
			end
		end
	end

	assign any_free = ~&rs_busy_i;
	// ~ack_q keeps a held word from being taken twice
	assign accept   = wb_cyc_i & wb_stb_i & ~ack_q & any_free & ~robp.full;
	assign wb_ack_o = ack_q;

	//==========================================================
	// operand lookup
	//==========================================================
	assign robp.rda_tag = map_tag[dec_srca];
	assign robp.rdb_tag = map_tag[dec_srcb];

	always_comb begin
		opa = lookup(map_vld[dec_srca], map_tag[dec_srca], arf[dec_srca],
				robp.rda_done, robp.rda_val, cdb_i);
		if (dec_op == OP_ADDI) begin
			opb.rdy   = 1'b1;
			opb.tag   = '0;
			opb.value = word_t'(dec_imm);	// zero extend
		end else begin
			opb = lookup(map_vld[dec_srcb], map_tag[dec_srcb], arf[dec_srcb],
					robp.rdb_done, robp.rdb_val, cdb_i);
		end
	end

	assign disp.alloc_onehot = accept ? free_onehot : '0;
	assign disp.op           = dec_op;
	assign disp.dest         = robp.tail;
	assign disp.opa          = opa;
	assign disp.opb          = opb;

	assign robp.alloc_en     = accept;
	assign robp.alloc_areg   = dec_dest;

	//==========================================================
	// map table and arch regs
	//==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ack_q   <= 1'b0;
			map_vld <= '0;
			for (int r = 0; r < `OOO_AREG_NUM; r++) begin
				arf[r]     <= '0;
				map_tag[r] <= '0;
			end
		end else begin
			ack_q <= accept;
			if (robp.retire_vld) begin
				arf[robp.retire_areg] <= robp.retire_val;
				// keep the mapping if a younger producer took the reg
				if (map_tag[robp.retire_areg] == robp.retire_tag)
					map_vld[robp.retire_areg] <= 1'b0;
			end
			if (accept) begin	// new producer overrides a retire clear
				map_vld[dec_dest] <= 1'b1;
				map_tag[dec_dest] <= robp.tail;
			end
		end
	end

endmodule: rename_unit

// File: hdl/rs_entry.sv
`timescale 1ns/10ps

module rs_entry (
	input  logic				clk,
	input  logic				rst_n_i,
	dispatch_if.entry			disp,
	input  logic				entry_sel_i,	// this entry's alloc bit
	input  ooo_pkg::cdb_t		cdb_i,
	input  logic				grant_i,
	output logic				busy_o,
	output logic				ready_o,
	output ooo_pkg::rs_issue_t	issue_o
);
	import ooo_pkg::*;

	rs_state_e	state_q, state_d;
	alu_op_e	op_q;
	rob_tag_t	dest_q;
	operand_t	opa_q, opb_q;
	logic		hit_a, hit_b;

	// tag match on the bus, only while waiting
	assign hit_a = (state_q == RS_WAIT) && cdb_i.valid && !opa_q.rdy && (cdb_i.tag == opa_q.tag);
	assign hit_b = (state_q == RS_WAIT) && cdb_i.valid && !opb_q.rdy && (cdb_i.tag == opb_q.tag);

	always_comb begin
		state_d = state_q;
		case (state_q)
			RS_FREE: begin
				if (entry_sel_i)
					state_d = (disp.opa.rdy && disp.opb.rdy) ? RS_READY : RS_WAIT;
			end
			RS_WAIT: begin
				if ((opa_q.rdy || hit_a) && (opb_q.rdy || hit_b))
					state_d = RS_READY;
			end
			RS_READY: begin
				if (grant_i)
					state_d = RS_FREE;	// free again at next edge
			end
			default: state_d = RS_FREE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			state_q <= RS_FREE;
		else
			state_q <= state_d;
	end

	// payload, loaded on alloc then patched from the bus
	always_ff @(posedge clk) begin
		if (entry_sel_i) begin
			op_q   <= disp.op;
			dest_q <= disp.dest;
			opa_q  <= disp.opa;
			opb_q  <= disp.opb;
		end else begin
			if (hit_a) begin
				opa_q.rdy   <= 1'b1;
				opa_q.value <= cdb_i.value;
			end
			if (hit_b) begin
				opb_q.rdy   <= 1'b1;
				opb_q.value <= cdb_i.value;
			end
		end
	end

	assign busy_o  = (state_q != RS_FREE);
	assign ready_o = (state_q == RS_READY);
	assign issue_o = '{op: op_q, dest: dest_q, val_a: opa_q.value, val_b: opb_q.value};

endmodule: rs_entry

// File: hdl/issue_alu.sv
`timescale 1ns/10ps
`include "ooo_macros.svh"

module issue_alu (
	input  logic									clk,
	input  logic									rst_n_i,
	input  logic [`OOO_RS_NUM-1:0]					rs_ready_i,
	input  ooo_pkg::rs_issue_t [`OOO_RS_NUM-1:0]	rs_issue_i,
	output logic [`OOO_RS_NUM-1:0]					grant_o,
	output ooo_pkg::cdb_t							cdb_o
);
	import ooo_pkg::*;

	rs_issue_t	sel;
	word_t		result;
	logic		cdb_vld_q;
	rob_tag_t	cdb_tag_q;
	word_t		cdb_val_q;

	//==========================================================
	// select, lowest ready index
	//==========================================================
	always_comb begin
		grant_o = '0;
		sel     = rs_issue_i[0];
		for (int i = `OOO_RS_NUM-1; i >= 0; i--) begin
			if (rs_ready_i[i]) begin
				grant_o    = '0;
				grant_o[i] = 1'b1;
				sel        = rs_issue_i[i];
			end
		end
	end

	//==========================================================
	// execute
	//==========================================================
	always_comb begin
		case (sel.op)
			OP_ADD:  result = sel.val_a + sel.val_b;	// wraps at 16 bits
			OP_SUB:  result = sel.val_a - sel.val_b;
			OP_AND:  result = sel.val_a & sel.val_b;
			OP_OR:   result = sel.val_a | sel.val_b;
			OP_XOR:  result = sel.val_a ^ sel.val_b;
			OP_ADDI: result = sel.val_a + sel.val_b;	// b already holds imm
			OP_SHL:  result = sel.val_a << sel.val_b[3:0];
			OP_SHR:  result = sel.val_a >> sel.val_b[3:0];
			default: result = '0;
		endcase
	end

	// result broadcast one cycle after grant
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			cdb_vld_q <= 1'b0;
		else
			cdb_vld_q <= |rs_ready_i;
	end

	always_ff @(posedge clk) begin
		cdb_tag_q <= sel.dest;
		cdb_val_q <= result;
	end

	assign cdb_o = '{valid: cdb_vld_q, tag: cdb_tag_q, value: cdb_val_q};

endmodule: issue_alu

// File: hdl/rob.sv
`timescale 1ns/10ps
`include "ooo_macros.svh"

module rob (
	input  logic			clk,
	input  logic			rst_n_i,
	rob_if.rob				robp,
	input  ooo_pkg::cdb_t	cdb_i
);
	import ooo_pkg::*;

	rob_tag_t					head, tail;
	logic [`OOO_ROB_W:0]		count;		// one extra bit to tell full from empty
	logic [`OOO_ROB_DEPTH-1:0]	done;
	logic						head_rdy;

	areg_t	slot_areg [`OOO_ROB_DEPTH];
	word_t	slot_val  [`OOO_ROB_DEPTH];

	logic		rtr_vld_q;
	rob_tag_t	rtr_tag_q;
	areg_t		rtr_areg_q;
	word_t		rtr_val_q;

	// oldest instr finished
	assign head_rdy = (count != '0) && done[head];

	//==========================================================
	// pointers and status
	//==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			done      <= '0;
			rtr_vld_q <= 1'b0;
		end else begin
			if (robp.alloc_en) begin
				tail       <= tail + 1'b1;	// wraps at depth
				done[tail] <= 1'b0;
			end
			if (cdb_i.valid)
				done[cdb_i.tag] <= 1'b1;
			if (head_rdy)
				head <= head + 1'b1;
			count <= count + (`OOO_ROB_W+1)'(robp.alloc_en)
					- (`OOO_ROB_W+1)'(head_rdy);
			rtr_vld_q <= head_rdy;
		end
	end

	// slot payload and the registered retire port
	always_ff @(posedge clk) begin
		if (robp.alloc_en)
			slot_areg[tail] <= robp.alloc_areg;
		if (cdb_i.valid)
			slot_val[cdb_i.tag] <= cdb_i.value;
		if (head_rdy) begin
			rtr_tag_q  <= head;
			rtr_areg_q <= slot_areg[head];
			rtr_val_q  <= slot_val[head];
		end
	end

	//==========================================================
	// outputs
	//==========================================================
	assign robp.tail = tail;
	assign robp.full = (count == (`OOO_ROB_W+1)'(`OOO_ROB_DEPTH));

	// done and value stay valid until the slot is reused
	assign robp.rda_done = done[robp.rda_tag];
	assign robp.rda_val  = slot_val[robp.rda_tag];
	assign robp.rdb_done = done[robp.rdb_tag];
	assign robp.rdb_val  = slot_val[robp.rdb_tag];

	assign robp.retire_vld  = rtr_vld_q;
	assign robp.retire_tag  = rtr_tag_q;
	assign robp.retire_areg = rtr_areg_q;
	assign robp.retire_val  = rtr_val_q;

endmodule: rob

// File: hdl/ooo_core.sv
`timescale 1ns/10ps
`include "ooo_macros.svh"

module ooo_core (
	input  logic			clk,
	input  logic			rst_n_i,

	// wishbone classic slave, write only
	input  logic			wb_cyc_i,
	input  logic			wb_stb_i,
	input  ooo_pkg::word_t	wb_dat_i,
	output logic			wb_ack_o,

	// retire report
	output logic			retire_vld_o,
	output ooo_pkg::areg_t	retire_areg_o,
	output ooo_pkg::word_t	retire_val_o
);
	import ooo_pkg::*;

	dispatch_if	disp ();
	rob_if		robp ();

	cdb_t							cdb;
	logic [`OOO_RS_NUM-1:0]			rs_busy;
	logic [`OOO_RS_NUM-1:0]			rs_ready;
	logic [`OOO_RS_NUM-1:0]			rs_grant;
	rs_issue_t [`OOO_RS_NUM-1:0]	rs_issue;

	//==========================================================
	// rename and dispatch
	//==========================================================
	rename_unit rename_unit (
		.clk		(clk),
		.rst_n_i	(rst_n_i),
		.wb_cyc_i	(wb_cyc_i),
		.wb_stb_i	(wb_stb_i),
		.wb_dat_i	(wb_dat_i),
		.wb_ack_o	(wb_ack_o),
		.rs_busy_i	(rs_busy),
		.cdb_i		(cdb),		// forwarding during dispatch
		.disp		(disp),
		.robp		(robp)
	);

	//==========================================================
	// reservation stations
	//==========================================================
	for (genvar g = 0; g < `OOO_RS_NUM; g++) begin : g_rs
		rs_entry rs_entry (
			.clk			(clk),
			.rst_n_i		(rst_n_i),
			.disp			(disp),
			.entry_sel_i	(disp.alloc_onehot[g]),
			.cdb_i			(cdb),
			.grant_i		(rs_grant[g]),
			.busy_o			(rs_busy[g]),
			.ready_o		(rs_ready[g]),
			.issue_o		(rs_issue[g])
		);
	end

	//==========================================================
	// select, execute, broadcast
	//==========================================================
	issue_alu issue_alu (
		.clk		(clk),
		.rst_n_i	(rst_n_i),
		.rs_ready_i	(rs_ready),
		.rs_issue_i	(rs_issue),
		.grant_o	(rs_grant),
		.cdb_o		(cdb)
	);

	rob rob (
		.clk		(clk),
		.rst_n_i	(rst_n_i),
		.robp		(robp),
		.cdb_i		(cdb)
	);

	assign retire_vld_o  = robp.retire_vld;
	assign retire_areg_o = robp.retire_areg;
	assign retire_val_o  = robp.retire_val;

endmodule: ooo_core

// File: bench/ooo_core_properties.sv
`timescale 1ns/10ps

module ooo_core_properties (
	input logic	clk,
	input logic	rst_n_i,
	input logic	wb_cyc_i,
	input logic	wb_stb_i,
	input logic	wb_ack_i,
	input logic	retire_vld_i
);
	int unsigned fail_cnt = 0;	// failed assertions so far

	// classic ack is a single pulse
	ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_i |=> !wb_ack_i)
	else begin
		$error("wb ack high two cycles in a row");
		fail_cnt = fail_cnt + 1;
	end

	// ack is registered, so the request sits one cycle earlier
	ack_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
	else begin
		$error("wb ack without cyc and stb");
		fail_cnt = fail_cnt + 1;
	end

	// sync reset, quiet from the edge after it is seen
	rst_quiet: assert property (@(posedge clk)
		!rst_n_i |=> !retire_vld_i)
	else begin
		$error("retire valid during reset");
		fail_cnt = fail_cnt + 1;
	end

endmodule: ooo_core_properties

bind ooo_core ooo_core_properties props (
	.clk			(clk),
	.rst_n_i		(rst_n_i),
	.wb_cyc_i		(wb_cyc_i),
	.wb_stb_i		(wb_stb_i),
	.wb_ack_i		(wb_ack_o),
	.retire_vld_i	(retire_vld_o)
);

// File: bench/tb_ooo_core.sv
`timescale 1ns/10ps
`include "ooo_macros.svh"

module tb_ooo_core;
	import ooo_pkg::*;

	localparam int TOTAL_INSTR = 15 + 8 + 12 + 40;	// all directed and random words
	localparam int ACK_WAIT    = 100;	// cycles before an ack counts as stuck
	localparam int DRAIN_WAIT  = 200;

	logic	clk;
	logic	rst_n;
	logic	wb_cyc, wb_stb, wb_ack;
	word_t	wb_dat;
	logic	retire_vld;
	areg_t	retire_areg;
	word_t	retire_val;

	integer	seed;
	string	test_name;
	word_t	model_regs [`OOO_AREG_NUM];	// architectural state in program order
	areg_t	exp_areg_q [$];
	word_t	exp_val_q [$];

	ooo_core DUT (
		.clk			(clk),
		.rst_n_i		(rst_n),
		.wb_cyc_i		(wb_cyc),
		.wb_stb_i		(wb_stb),
		.wb_dat_i		(wb_dat),
		.wb_ack_o		(wb_ack),
		.retire_vld_o	(retire_vld),
		.retire_areg_o	(retire_areg),
		.retire_val_o	(retire_val)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	//============================================================
	// reporting and compare
	//============================================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic compare_areg(input string test, input areg_t exp, input areg_t act);
		if (act !== exp)
			abort_run($sformatf("mismatch %s retire areg expected %0d actual %0d",
					test, exp, act));
	endtask

	task automatic compare_word(input string test, input word_t exp, input word_t act);
		if (act !== exp)
			abort_run($sformatf("mismatch %s retire value expected 0x%04h actual 0x%04h",
					test, exp, act));
	endtask

	//============================================================
	// reference model
	//============================================================
	function automatic word_t encode(input alu_op_e op, input areg_t d, input areg_t a,
			input areg_t b, input logic [3:0] imm);
		return {op, d, a, b, imm};
	endfunction

	function automatic word_t expected_result(input word_t w);
		word_t a, b;
		a = model_regs[w[9:7]];
		b = model_regs[w[6:4]];
		case (alu_op_e'(w[15:13]))
			OP_ADD:  return a + b;	// 16 bit wrap
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_ADDI: return a + {12'd0, w[3:0]};
			OP_SHL:  return a << b[3:0];
			OP_SHR:  return a >> b[3:0];
			default: return '0;
		endcase
	endfunction

	//============================================================
	// stimulus
	//============================================================
	// one classic write, held until ack, starts on a falling edge
	task automatic send_instr(input word_t w);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_dat = w;
		do begin
			@(negedge clk);
			waited++;
			if (waited > ACK_WAIT)
				abort_run($sformatf("no ack for word 0x%04h in %s", w, test_name));
		end while (!wb_ack);
	endtask

	task automatic issue_word(input word_t w);
		word_t res;
		res = expected_result(w);
		exp_areg_q.push_back(w[12:10]);
		exp_val_q.push_back(res);
		model_regs[w[12:10]] = res;	// program order update
		send_instr(w);
	endtask

	task automatic release_bus();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// every pushed expectation must come back as a retire
	task automatic wait_retired();
		int waited;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			if (waited > DRAIN_WAIT)
				abort_run($sformatf("missing retire in %s, %0d instructions never retired",
						test_name, exp_areg_q.size()));
		end while (exp_areg_q.size() != 0);
	endtask

	// retire monitor, sampled mid cycle
	always @(negedge clk) begin
		if (rst_n && retire_vld) begin
			if (exp_areg_q.size() == 0) begin
				abort_run($sformatf("unexpected retire in %s with nothing pending", test_name));
			end else begin
				compare_areg(test_name, exp_areg_q.pop_front(), retire_areg);
				compare_word(test_name, exp_val_q.pop_front(), retire_val);
			end
		end
	end

	//============================================================
	// directed tests
	//============================================================
	task automatic test_reset();
		test_name = "test_reset";
		repeat (10) begin
			@(negedge clk);
			if (wb_ack)
				abort_run("wb ack raised while cyc was low after reset");
		end
	endtask

	task automatic test_each_opcode();
		test_name = "test_each_opcode";
		@(negedge clk);
		issue_word(encode(OP_ADDI, 3'd1, 3'd0, 3'd0, 4'd12));	// constants
		issue_word(encode(OP_ADDI, 3'd2, 3'd0, 3'd0, 4'd5));
		issue_word(encode(OP_ADDI, 3'd3, 3'd0, 3'd0, 4'd9));
		issue_word(encode(OP_ADDI, 3'd4, 3'd0, 3'd0, 4'd3));
		issue_word(encode(OP_ADDI, 3'd5, 3'd0, 3'd0, 4'd15));
		issue_word(encode(OP_ADDI, 3'd6, 3'd0, 3'd0, 4'd10));
		issue_word(encode(OP_ADDI, 3'd7, 3'd0, 3'd0, 4'd7));
		issue_word(encode(OP_ADD,  3'd0, 3'd1, 3'd2, 4'd0));
		issue_word(encode(OP_SUB,  3'd1, 3'd3, 3'd5, 4'd0));	// wraps below zero
		issue_word(encode(OP_AND,  3'd2, 3'd5, 3'd6, 4'd0));
		issue_word(encode(OP_OR,   3'd3, 3'd4, 3'd7, 4'd0));
		issue_word(encode(OP_XOR,  3'd4, 3'd6, 3'd7, 4'd0));
		issue_word(encode(OP_ADDI, 3'd5, 3'd7, 3'd0, 4'd9));
		issue_word(encode(OP_SHL,  3'd6, 3'd7, 3'd3, 4'd0));
		issue_word(encode(OP_SHR,  3'd7, 3'd1, 3'd2, 4'd0));
		release_bus();
		wait_retired();
	endtask

	// each word reads the previous destination
	task automatic test_dependency_chain();
		test_name = "test_dependency_chain";
		@(negedge clk);
		issue_word(encode(OP_ADDI, 3'd1, 3'd1, 3'd0, 4'd1));
		issue_word(encode(OP_ADD,  3'd2, 3'd1, 3'd1, 4'd0));
		issue_word(encode(OP_SUB,  3'd3, 3'd2, 3'd1, 4'd0));
		issue_word(encode(OP_SHL,  3'd4, 3'd3, 3'd0, 4'd0));
		issue_word(encode(OP_XOR,  3'd5, 3'd4, 3'd2, 4'd0));
		issue_word(encode(OP_OR,   3'd6, 3'd5, 3'd3, 4'd0));
		issue_word(encode(OP_ADDI, 3'd7, 3'd6, 3'd0, 4'd15));
		issue_word(encode(OP_AND,  3'd1, 3'd7, 3'd5, 4'd0));
		release_bus();
		wait_retired();
	endtask

	// dense stream on one chain, ack may be held back
	task automatic test_backpressure();
		test_name = "test_backpressure";
		@(negedge clk);
		for (int i = 0; i < 6; i++)
			issue_word(encode(OP_ADD, 3'd1, 3'd1, 3'd2, 4'd0));
		for (int i = 0; i < 6; i++)
			issue_word(encode(i[0] ? OP_SUB : OP_ADDI, 3'(2 + i), 3'd1, 3'(7 - i), 4'(i)));
		release_bus();
		wait_retired();
	endtask

	task automatic test_random();
		word_t w;
		test_name = "test_random";
		@(negedge clk);
		for (int i = 0; i < 40; i++) begin
			w = word_t'($random(seed));	// any opcode, any registers
			issue_word(w);
		end
		release_bus();
		wait_retired();
	endtask

	//============================================================
	// main sequence and watchdog
	//============================================================
	initial begin
		seed   = 32'hf901;
		rst_n  = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_dat = '0;
		test_name = "reset";
		for (int r = 0; r < `OOO_AREG_NUM; r++)
			model_regs[r] = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_each_opcode();
		test_dependency_chain();
		test_backpressure();
		test_random();
		@(negedge clk);
		if (DUT.props.fail_cnt == 0) begin
			$display("test passed");
			$finish;
		end else begin
			abort_run($sformatf("%0d assertion failures were reported", DUT.props.fail_cnt));
		end
	end

	initial begin
		repeat (TOTAL_INSTR * 40) @(posedge clk);
		abort_run("watchdog timeout, the tests did not finish in time");
	end

endmodule: tb_ooo_core

// File: src.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/ooo_ifs.sv
hdl/rename_unit.sv
hdl/rs_entry.sv
hdl/issue_alu.sv
hdl/rob.sv
hdl/ooo_core.sv
bench/ooo_core_properties.sv
bench/tb_ooo_core.sv

// File: Bender.yml
package:
  name: ooo_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ooo_pkg.sv
      - hdl/ooo_ifs.sv
      - hdl/rename_unit.sv
      - hdl/rs_entry.sv
      - hdl/issue_alu.sv
      - hdl/rob.sv
      - hdl/ooo_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/ooo_core_properties.sv
      - bench/tb_ooo_core.sv
